/* include/nx_bridge_cfg.svh */
`ifndef NX_BRIDGE_CFG_SVH
`define NX_BRIDGE_CFG_SVH

// Bus field widths shared by both sides of the bridge
`define NX_ADDR_W 31
`define NX_DATA_W 64
`define NX_ID_W   4
`define NX_TYPE_W 3
`define NX_SIZE_W 8
`define NX_ATTR_W 3

// The request buffer depth must be a power of two
`define NX_FIFO_DEPTH 4

`endif

/* source/nx_bus_pkg.sv */
`default_nettype none

`include "nx_bridge_cfg.svh"

package nx_bus_pkg;

    // ##################################################################
    // Channel words of the request bus
    // ##################################################################

    // Command request word
    typedef struct packed {
        logic [`NX_TYPE_W-1:0] cmd_type;
        logic [`NX_ATTR_W-1:0] attr;
        logic [`NX_SIZE_W-1:0] size;
        logic [`NX_ID_W-1:0]   id;
        logic [`NX_ADDR_W-1:0] addr;
    } nx_creq_t;

    // Write data beat that follows a write command
    typedef struct packed {
        logic [`NX_ID_W-1:0]   id;
        logic [`NX_DATA_W-1:0] data;
        logic [`NX_ATTR_W-1:0] attr;
    } nx_dreq_t;

    // Read return from the slave
    typedef struct packed {
        logic [`NX_ID_W-1:0]   id;
        logic [`NX_DATA_W-1:0] data;
        logic [`NX_ATTR_W-1:0] attr;
    } nx_rreq_t;

    // Command type codes. Every code other than write is read-class
    localparam logic [`NX_TYPE_W-1:0] NX_TYPE_READ  = `NX_TYPE_W'(0);
    localparam logic [`NX_TYPE_W-1:0] NX_TYPE_WRITE = `NX_TYPE_W'(1);

endpackage

`default_nettype wire

/* source/nx_bridge_pkg.sv */
`default_nettype none

`include "nx_bridge_cfg.svh"

package nx_bridge_pkg;

    // Index width into the request buffer
    localparam int NX_IDX_W = $clog2(`NX_FIFO_DEPTH);

    // Buffer pointer with one extra wrap bit on top
    typedef logic [NX_IDX_W:0] nx_ptr_t;

    // One queued request. The data beat is all zero for read-class commands
    typedef struct packed {
        nx_bus_pkg::nx_creq_t creq;
        logic                 has_data;
        nx_bus_pkg::nx_dreq_t dreq;
    } nx_entry_t;

endpackage

`default_nettype wire

/* source/nx_req_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module nx_req_capture (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 creq_valid,
    input  wire nx_bus_pkg::nx_creq_t creq,
    output logic                      creq_rdstall,
    output logic                      creq_wrstall,
    input  wire logic                 dreq_valid,
    input  wire nx_bus_pkg::nx_dreq_t dreq,
    output logic                      dreq_stall,
    output logic                      push,
    output nx_bridge_pkg::nx_entry_t  push_entry,
    input  wire logic                 full
);
    import nx_bus_pkg::*;
    import nx_bridge_pkg::*;

    logic     pend_valid;
    nx_creq_t pend_creq;
    logic     cmd_is_write;
    logic     rd_accept;
    logic     wr_accept;
    logic     beat_accept;

    assign cmd_is_write = (creq.cmd_type == NX_TYPE_WRITE);

    // Commands wait while a write still needs its beat, so order holds
    assign creq_rdstall = full || pend_valid;
    assign creq_wrstall = full || pend_valid;

    // A beat is only taken for the pending write
    assign dreq_stall = !pend_valid || full;

    assign rd_accept   = creq_valid && !cmd_is_write && !creq_rdstall;
    assign wr_accept   = creq_valid && cmd_is_write && !creq_wrstall;
    assign beat_accept = dreq_valid && !dreq_stall;

    // rd_accept and beat_accept never coincide since one needs pend_valid low
    assign push = rd_accept || beat_accept;

    always_comb begin
        push_entry = '0;
        if (beat_accept) begin
            push_entry.creq     = pend_creq;
            push_entry.has_data = 1'b1;
            push_entry.dreq     = dreq;
        end else begin
            push_entry.creq = creq;
        end
    end

    // ##################################################################
    // Pending write command
    // ##################################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_valid <= 1'b0;
        end else if (wr_accept) begin
            pend_valid <= 1'b1;
        end else if (beat_accept) begin
            pend_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            pend_creq <= creq;
        end
    end

endmodule

`default_nettype wire

/* source/nx_req_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nx_bridge_cfg.svh"

module nx_req_fifo (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     push,
    input  wire nx_bridge_pkg::nx_entry_t push_entry,
    input  wire logic                     pop,
    output nx_bridge_pkg::nx_entry_t      head,
    output logic                          full,
    output logic                          empty
);
    import nx_bridge_pkg::*;

    nx_entry_t mem [`NX_FIFO_DEPTH];
    nx_ptr_t   wr_ptr;
    nx_ptr_t   rd_ptr;
    logic      do_push;
    logic      do_pop;

    // Same index with different wrap bits means every slot is taken
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[NX_IDX_W] != rd_ptr[NX_IDX_W]) &&
                   (wr_ptr[NX_IDX_W-1:0] == rd_ptr[NX_IDX_W-1:0]);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head = mem[rd_ptr[NX_IDX_W-1:0]];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[NX_IDX_W-1:0]] <= push_entry;
        end
    end

endmodule

`default_nettype wire

/* source/nx_req_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module nx_req_issue (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire nx_bridge_pkg::nx_entry_t head,
    input  wire logic                     empty,
    output logic                          pop,
    output logic                          creq_valid,
    output nx_bus_pkg::nx_creq_t          creq,
    input  wire logic                     creq_rdstall,
    input  wire logic                     creq_wrstall,
    output logic                          dreq_valid,
    output nx_bus_pkg::nx_dreq_t          dreq,
    input  wire logic                     dreq_stall
);
    import nx_bus_pkg::*;
    import nx_bridge_pkg::*;

    nx_entry_t out_entry;
    logic      cmd_pend;
    logic      dat_pend;
    logic      out_is_write;
    logic      cmd_done;
    logic      dat_done;
    logic      finishing;
    logic      load;

    // Only write entries carry a data beat
    assign out_is_write = out_entry.has_data;

    // Each channel completes on its own transfer
    assign cmd_done = cmd_pend && !(out_is_write ? creq_wrstall : creq_rdstall);
    assign dat_done = dat_pend && !dreq_stall;

    // True when the register is idle or its last open channel transfers now
    assign finishing = (!cmd_pend || cmd_done) && (!dat_pend || dat_done);
    assign load      = !empty && finishing;
    assign pop       = load;

    assign creq_valid = cmd_pend;
    assign dreq_valid = dat_pend;
    assign creq       = out_entry.creq;
    assign dreq       = out_entry.dreq;

    // ##################################################################
    // Output register and channel tracking
    // ##################################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_pend <= 1'b0;
            dat_pend <= 1'b0;
        end else if (load) begin
            cmd_pend <= 1'b1;
            dat_pend <= head.has_data;
        end else begin
            if (cmd_done) begin
                cmd_pend <= 1'b0;
            end
            if (dat_done) begin
                dat_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_entry <= head;
        end
    end

endmodule

`default_nettype wire

/* source/nx_bridge_top.sv */
`timescale 1ns/1ps
`default_nettype none

module nx_bridge_top (
    input  wire logic                 clk,
    input  wire logic                 rst_n,

    // Master side
    input  wire logic                 m_creq_valid,
    input  wire nx_bus_pkg::nx_creq_t m_creq,
    output logic                      m_creq_rdstall,
    output logic                      m_creq_wrstall,
    input  wire logic                 m_dreq_valid,
    input  wire nx_bus_pkg::nx_dreq_t m_dreq,
    output logic                      m_dreq_stall,
    output logic                      m_rreq_valid,
    output nx_bus_pkg::nx_rreq_t      m_rreq,
    input  wire logic                 m_rreq_stall,

    // Slave side
    output logic                      s_creq_valid,
    output nx_bus_pkg::nx_creq_t      s_creq,
    input  wire logic                 s_creq_rdstall,
    input  wire logic                 s_creq_wrstall,
    output logic                      s_dreq_valid,
    output nx_bus_pkg::nx_dreq_t      s_dreq,
    input  wire logic                 s_dreq_stall,
    input  wire logic                 s_rreq_valid,
    input  wire nx_bus_pkg::nx_rreq_t s_rreq,
    output logic                      s_rreq_stall
);
    import nx_bridge_pkg::*;

    logic      push;
    nx_entry_t push_entry;
    logic      full;
    nx_entry_t head;
    logic      empty;
    logic      pop;

    nx_req_capture capture0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .creq_valid   (m_creq_valid),
        .creq         (m_creq),
        .creq_rdstall (m_creq_rdstall),
        .creq_wrstall (m_creq_wrstall),
        .dreq_valid   (m_dreq_valid),
        .dreq         (m_dreq),
        .dreq_stall   (m_dreq_stall),
        .push         (push),
        .push_entry   (push_entry),
        .full         (full)
    );

    nx_req_fifo fifo0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_entry (push_entry),
        .pop        (pop),
        .head       (head),
        .full       (full),
        .empty      (empty)
    );

    nx_req_issue issue0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .head         (head),
        .empty        (empty),
        .pop          (pop),
        .creq_valid   (s_creq_valid),
        .creq         (s_creq),
        .creq_rdstall (s_creq_rdstall),
        .creq_wrstall (s_creq_wrstall),
        .dreq_valid   (s_dreq_valid),
        .dreq         (s_dreq),
        .dreq_stall   (s_dreq_stall)
    );

    // Read returns go straight through with no added latency
    assign m_rreq_valid = s_rreq_valid;
    assign m_rreq       = s_rreq;
    assign s_rreq_stall = m_rreq_stall;

endmodule

`default_nettype wire

/* verification/tb_nx_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nx_bridge_cfg.svh"

module tb_nx_bridge;
    import nx_bus_pkg::*;
    import nx_bridge_pkg::*;

    localparam int TOTAL_REQS = 300;
    localparam int WAIT_LIMIT = 200;
    localparam int RUN_LIMIT  = 40000;

    logic     clk = 1'b0;
    logic     rst_n = 1'b0;
    logic     m_creq_valid = 1'b0;
    nx_creq_t m_creq = '0;
    logic     m_dreq_valid = 1'b0;
    nx_dreq_t m_dreq = '0;
    logic     m_rreq_stall = 1'b0;
    logic     s_creq_rdstall = 1'b0;
    logic     s_creq_wrstall = 1'b0;
    logic     s_dreq_stall = 1'b0;
    logic     s_rreq_valid = 1'b0;
    nx_rreq_t s_rreq = '0;
    logic     m_creq_rdstall, m_creq_wrstall, m_dreq_stall, m_rreq_valid;
    logic     s_creq_valid, s_dreq_valid, s_rreq_stall;
    nx_rreq_t m_rreq;
    nx_creq_t s_creq;
    nx_dreq_t s_dreq;

    // The slave never stalls in mode 0, always stalls in mode 1 and stalls at random in mode 2
    logic [1:0] slave_mode = 2'd0;
    nx_entry_t  exp_q[$];
    nx_creq_t   wr_hold;
    logic       cmd_seen = 1'b0;
    logic       dat_seen = 1'b0;
    int         done_cnt = 0;
    int         issued_cnt = 0;
    logic       beat_wait = 1'b0;
    int         beat_delay = 0;
    logic       cmd_taken_now = 1'b0;

    always #20 clk = ~clk;

    nx_bridge_top dut0 (.*);

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Expected queue entry for an accepted command and, for a write, its beat
    function automatic nx_entry_t nx_ref_entry(input nx_creq_t cmd, input nx_dreq_t beat);
        nx_entry_t e;
        e.creq     = cmd;
        e.has_data = (cmd.cmd_type == NX_TYPE_WRITE);
        e.dreq     = e.has_data ? beat : '0;
        return e;
    endfunction

    function automatic nx_creq_t rand_cmd(input logic writes_ok);
        nx_creq_t c;
        c.cmd_type = `NX_TYPE_W'($urandom);
        if (c.cmd_type == NX_TYPE_WRITE && !writes_ok) begin
            c.cmd_type = NX_TYPE_READ;
        end else if (writes_ok && ($urandom % 3) == 0) begin
            c.cmd_type = NX_TYPE_WRITE;
        end
        c.attr = `NX_ATTR_W'($urandom);
        c.size = `NX_SIZE_W'($urandom);
        c.id   = `NX_ID_W'($urandom);
        c.addr = `NX_ADDR_W'($urandom);
        return c;
    endfunction

    // ##################################################################
    // Master model called once per rising edge by the stimulus process
    // ##################################################################

    task automatic drive_cycle(input logic want_new, input logic writes_ok);
        logic is_wr;
        logic beat_taken;
        is_wr         = (m_creq.cmd_type == NX_TYPE_WRITE);
        cmd_taken_now = m_creq_valid && !(is_wr ? m_creq_wrstall : m_creq_rdstall);
        beat_taken    = m_dreq_valid && !m_dreq_stall;
        if (cmd_taken_now) begin
            issued_cnt++;
            if (is_wr) begin
                beat_wait  = 1'b1;
                beat_delay = int'($urandom % 4);
            end
        end
        if (beat_taken) begin
            m_dreq_valid <= 1'b0;
            beat_wait = 1'b0;
        end else if (beat_wait && !m_dreq_valid) begin
            if (beat_delay == 0) begin
                m_dreq_valid <= 1'b1;
                m_dreq.id    <= `NX_ID_W'($urandom);
                m_dreq.data  <= {$urandom, $urandom};
                m_dreq.attr  <= `NX_ATTR_W'($urandom);
            end else begin
                beat_delay--;
            end
        end
        if (cmd_taken_now || !m_creq_valid) begin
            m_creq_valid <= want_new && (issued_cnt < TOTAL_REQS);
            m_creq       <= rand_cmd(writes_ok);
        end
    endtask

    // Slave model with random read returns
    always @(posedge clk) begin
        s_creq_rdstall <= (slave_mode == 2'd1) || (slave_mode == 2'd2 && ($urandom % 3) == 0);
        s_creq_wrstall <= (slave_mode == 2'd1) || (slave_mode == 2'd2 && ($urandom % 3) == 0);
        s_dreq_stall   <= (slave_mode == 2'd1) || (slave_mode == 2'd2 && ($urandom % 3) == 0);
        m_rreq_stall   <= ($urandom % 4) == 0;
        s_rreq_valid   <= ($urandom % 2) == 0;
        s_rreq.id      <= `NX_ID_W'($urandom);
        s_rreq.data    <= {$urandom, $urandom};
        s_rreq.attr    <= `NX_ATTR_W'($urandom);
    end

    // ##################################################################
    // Expected queue and ordered comparison
    // ##################################################################

    always @(posedge clk) begin
        if (rst_n) begin
            assert (m_rreq_valid == s_rreq_valid && m_rreq == s_rreq &&
                    s_rreq_stall == m_rreq_stall)
            else stop_on_error($sformatf("ERR @%0t: read return differs across ports", $time));
            if (s_creq_valid &&
                !(s_creq.cmd_type == NX_TYPE_WRITE ? s_creq_wrstall : s_creq_rdstall)) begin
                assert (exp_q.size() != 0 && !cmd_seen)
                else stop_on_error($sformatf("ERR @%0t: unexpected command %h", $time, s_creq));
                assert (s_creq == exp_q[0].creq)
                else stop_on_error($sformatf("ERR @%0t: command %h expected %h",
                                             $time, s_creq, exp_q[0].creq));
                cmd_seen = 1'b1;
            end
            if (s_dreq_valid && !s_dreq_stall) begin
                assert (exp_q.size() != 0 && exp_q[0].has_data && !dat_seen)
                else stop_on_error($sformatf("ERR @%0t: unexpected data beat %h", $time, s_dreq));
                assert (s_dreq == exp_q[0].dreq)
                else stop_on_error($sformatf("ERR @%0t: data beat %h expected %h",
                                             $time, s_dreq, exp_q[0].dreq));
                dat_seen = 1'b1;
            end
            if (cmd_seen && (dat_seen || !exp_q[0].has_data)) begin
                void'(exp_q.pop_front());
                cmd_seen = 1'b0;
                dat_seen = 1'b0;
                done_cnt++;
            end
            // Master side acceptances
            if (m_creq_valid && m_creq.cmd_type != NX_TYPE_WRITE && !m_creq_rdstall) begin
                exp_q.push_back(nx_ref_entry(m_creq, '0));
            end
            if (m_creq_valid && m_creq.cmd_type == NX_TYPE_WRITE && !m_creq_wrstall) begin
                wr_hold = m_creq;
            end
            if (m_dreq_valid && !m_dreq_stall) begin
                exp_q.push_back(nx_ref_entry(wr_hold, m_dreq));
            end
        end
    end

    initial begin
        int   t;
        int   base;
        logic stalled;
        void'($urandom(32'h1e3d));
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (!s_creq_valid && !s_dreq_valid && !m_creq_rdstall && !m_creq_wrstall &&
                m_dreq_stall)
        else stop_on_error($sformatf("ERR @%0t: bridge not idle after reset", $time));

        // One read into the idle bridge while the slave never stalls
        @(posedge clk);
        drive_cycle(1'b1, 1'b0);
        t = 0;
        do begin
            if (t >= WAIT_LIMIT) stop_on_error("Timeout waiting for the bridge to accept a read");
            @(posedge clk);
            drive_cycle(1'b0, 1'b0);
            t++;
        end while (!cmd_taken_now);
        t = 0;
        do begin
            if (t >= WAIT_LIMIT) stop_on_error("Timeout waiting for the read on the slave side");
            @(posedge clk);
            t++;
        end while (!s_creq_valid);
        assert (t == 2)
        else stop_on_error($sformatf("ERR @%0t: read latency %0d cycles, expected 2", $time, t));
        t = 0;
        do begin
            if (t >= WAIT_LIMIT) stop_on_error("Timeout waiting for the bridge to drain");
            @(negedge clk);
            t++;
        end while (exp_q.size() != 0 || s_creq_valid || s_dreq_valid);

        // Reads back to back into a blocked slave until the master is stalled
        @(posedge clk);
        slave_mode <= 2'd1;
        @(posedge clk);
        base    = issued_cnt;
        stalled = 1'b0;
        t       = 0;
        while (!stalled) begin
            if (t >= WAIT_LIMIT) stop_on_error("Timeout waiting for the master stall");
            drive_cycle(1'b1, 1'b0);
            @(posedge clk);
            stalled = m_creq_valid && m_creq_rdstall;
            t++;
        end
        assert (issued_cnt - base == `NX_FIFO_DEPTH + 1 && m_creq_wrstall)
        else stop_on_error($sformatf("ERR @%0t: master stalled after %0d requests",
                                     $time, issued_cnt - base));

        // Random traffic under random slave stalls
        slave_mode <= 2'd2;
        t = 0;
        do begin
            if (t >= RUN_LIMIT) stop_on_error("Timeout waiting for all requests to complete");
            @(posedge clk);
            drive_cycle(($urandom % 4) != 0, 1'b1);
            @(negedge clk);
            t++;
        end while (done_cnt < TOTAL_REQS || exp_q.size() != 0);

        if (done_cnt == TOTAL_REQS && exp_q.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            stop_on_error("More requests completed than the master issued");
        end
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
source/nx_bus_pkg.sv
source/nx_bridge_pkg.sv
source/nx_req_capture.sv
source/nx_req_fifo.sv
source/nx_req_issue.sv
source/nx_bridge_top.sv
verification/tb_nx_bridge.sv

/* Makefile */
TOP := tb_nx_bridge

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module nx_bridge_top

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
